// ==== hw/ctrl_defs.svh ====
`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

// Data path widths
`define DSP_WORD_W   16
`define T_FIELD_W    5

// Do loop field widths
`define DO_NI_W      4      // Body length, up to 15 words
`define DO_K_W       7      // Repeat count

// Opcode T field values
// The goto JA, short immediate and call JA entries ignore the lowest bit,
// so they are only meant for casez
`define OP_GOTO_JA   5'b0000?
`define OP_SHORT_IMM 5'b0001?
`define OP_CALL_JA   5'b1000?
`define OP_GOTO_B    5'b11000   // ret, iret, goto pt, call pt
`define OP_MOVE_A0   5'b01001   // R=a0
`define OP_MOVE_A1   5'b01011   // R=a1
`define OP_LONG_IMM  5'b01010   // R=imm, data in the next word
`define OP_IF_CON    5'b11010
`define OP_DO        5'b01110   // do and redo

// Bits 10:8 of goto B that select iret
`define IRET_CODE    3'd1

// Move destination codes
// Long immediate compares them against bits 9:7 with a zero on top,
// the accumulator moves against bits 8:7
`define DEST_YAAU    2'd0
`define DEST_XAAU    2'd1

`endif

// ==== hw/ctrl_pkg.sv ====
`include "ctrl_defs.svh"

package ctrl_pkg;

    typedef logic [`DSP_WORD_W-1:0] dsp_word_t;
    typedef logic [`T_FIELD_W-1:0]  t_field_t;
    typedef logic [`DO_NI_W-1:0]    do_ni_t;
    typedef logic [`DO_K_W-1:0]     do_k_t;

    // Branch and field view, address bits below the opcode
    typedef struct packed {
        t_field_t                           op;
        logic [`DSP_WORD_W-`T_FIELD_W-1:0]  addr;
    } branch_view_t;

    // do / redo word
    typedef struct packed {
        t_field_t op;
        do_ni_t   ni;     // 0 means redo
        do_k_t    k;
    } do_view_t;

    // Register moves and long immediate
    typedef struct packed {
        t_field_t    op;
        logic        a_sel;
        logic [2:0]  dest;     // Bits 9:7
        logic [2:0]  rsel;     // Target register, bits 6:4
        logic [3:0]  low;
    } move_view_t;

    // One program word seen through each decoding
    typedef union packed {
        branch_view_t branch;
        do_view_t     do_op;
        move_view_t   move;
    } dsp_instr_u;

endpackage

// ==== hw/irq_gate.sv ====
`timescale 1ns/1ps
`include "ctrl_defs.svh"

module irq_gate (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  ctrl_pkg::t_field_t  op,
    input  logic                irq,
    input  logic                do_busy,
    input  logic                double,
    input  logic                iret_seen,
    output logic                irq_take,
    output logic                iack
);
    import ctrl_pkg::*;

    logic clr_pend;     // iret seen, waiting for an interruptible word

    // Branches, if CON and do must not be split from what follows them
    function automatic logic no_irq_op(input t_field_t t);
        logic blocked;
        casez (t)
            `OP_GOTO_JA, `OP_CALL_JA, `OP_GOTO_B,
            `OP_IF_CON, `OP_DO: blocked = 1'b1;
            default:            blocked = 1'b0;
        endcase
        return blocked;
    endfunction

    // Only a word that is actually decoded can be replaced by the irq
    assign irq_take = irq && !double && !do_busy && !iack && !no_irq_op(op);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            iack     <= 1'b0;
            clr_pend <= 1'b0;
        end else if (cen) begin
            if (irq_take) begin
                iack     <= 1'b1;
                clr_pend <= 1'b0;
            end else if (iret_seen) begin
                clr_pend <= 1'b1;
            end else if (clr_pend && !double && !no_irq_op(op)) begin
                // Service routine has returned
                iack     <= 1'b0;
                clr_pend <= 1'b0;
            end
        end
    end

endmodule

// ==== hw/do_loop_ctrl.sv ====
`timescale 1ns/1ps

module do_loop_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic              do_load,
    input  ctrl_pkg::do_ni_t  do_ni_in,
    input  ctrl_pkg::do_k_t   do_k_in,
    input  logic              do_redo_req,
    input  logic              double,
    output logic              do_busy,
    output logic              do_stretch,
    output logic              do_start,
    output logic              do_out,
    output logic              do_short,
    output logic              do_redo,
    output logic              do_save,
    output ctrl_pkg::do_ni_t  do_pc
);
    import ctrl_pkg::*;

    do_ni_t ni_cnt;       // Words of the body already decoded
    do_ni_t ni_last;      // Body length minus one, kept for redo
    do_k_t  k_cnt;        // Passes left
    do_k_t  k_top;        // Pass count as loaded
    do_k_t  k_load;
    logic   redo_q;
    logic   first_done;
    logic   first_act;
    logic   first_end;
    logic   over;

    // Load cycle takes the word fields directly
    assign do_short  = do_load && !do_redo_req && (do_ni_in == do_ni_t'(1));
    assign do_save   = do_load && !do_redo_req;    // Body goes into the cache
    assign do_redo   = do_load ? do_redo_req : redo_q;
    assign first_act = do_load ? 1'b0 : first_done;

    // One word body stretches right away and runs one pass fewer
    assign k_load = do_short ? do_k_in - do_k_t'(1) : do_k_in;

    assign over     = ni_cnt == ni_last;
    assign do_busy  = k_cnt != '0;
    assign do_pc    = ni_cnt;

    // Last word of the first pass
    assign first_end = ((over && k_cnt == k_top && do_busy) || do_short) && !first_act;
    assign do_out    = do_busy && over && k_cnt == do_k_t'(1) && !double;
    assign do_start  = (!do_redo && first_end) || (do_redo && !do_busy);

    // Cache fill and loop exit both need an extra cycle
    assign do_stretch = (first_end && !do_redo) || do_out;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ni_cnt     <= '0;
            ni_last    <= '0;
            k_cnt      <= '0;
            k_top      <= '0;
            redo_q     <= 1'b0;
            first_done <= 1'b0;
        end else if (cen) begin
            if (do_load) begin
                // First body word of a do is decoded on this edge
                ni_cnt <= (do_redo_req || do_short) ? do_ni_t'(0) : do_ni_t'(1);
                k_cnt  <= k_load;
                k_top  <= k_load;
                redo_q <= do_redo_req;
                if (!do_redo_req) begin
                    ni_last <= do_ni_in - do_ni_t'(1);
                end
            end else if (!double && do_busy) begin
                ni_cnt <= over ? do_ni_t'(0) : ni_cnt + do_ni_t'(1);
                if (over) begin
                    k_cnt <= k_cnt - do_k_t'(1);   // One pass done
                end
            end
            if (do_out) begin
                redo_q <= 1'b0;
            end
            if (do_stretch) begin
                first_done <= 1'b1;
            end else if (do_load) begin
                first_done <= 1'b0;
            end
        end
    end

endmodule

// ==== hw/instr_decode.sv ====
`timescale 1ns/1ps
`include "ctrl_defs.svh"

module instr_decode (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  ctrl_pkg::dsp_word_t rom_dout,
    input  logic                con_result,
    input  logic                irq_take,
    input  logic                do_busy,
    input  logic                do_stretch,
    output logic                short_load,
    output logic                long_load,
    output logic                acc_load,
    output logic                xaau_imm_load,
    output logic                xaau_acc_load,
    output logic [2:0]          r_field,
    output logic [8:0]          short_imm,
    output ctrl_pkg::dsp_word_t long_imm,
    output logic [11:0]         i_field,
    output ctrl_pkg::t_field_t  t_field,
    output logic                con_check,
    output logic                goto_ja,
    output logic                goto_b,
    output logic                call_ja,
    output logic                pc_halt,
    output logic                irq_start,
    output logic                fault,
    output logic                double,
    output logic                iret_seen,
    output logic                do_load,
    output ctrl_pkg::do_ni_t    do_ni_in,
    output ctrl_pkg::do_k_t     do_k_in,
    output logic                do_redo_req
);
    import ctrl_pkg::*;

    dsp_instr_u instr;
    logic       con_ok;
    logic       is_iret;

    assign instr    = rom_dout;
    assign con_ok   = ~con_check | con_result;
    assign is_iret  = instr.branch.addr[10:8] == `IRET_CODE;
    assign long_imm = rom_dout;     // Data word follows the R=imm opcode

    // Fields, qualified by the strobes
    always_ff @(posedge clk) begin
        if (cen) begin
            t_field     <= instr.branch.op;
            i_field     <= rom_dout[11:0];
            short_imm   <= rom_dout[8:0];
            do_ni_in    <= instr.do_op.ni;
            do_k_in     <= instr.do_op.k;
            do_redo_req <= instr.do_op.ni == '0;
            casez (instr.branch.op)
                `OP_SHORT_IMM: r_field <= rom_dout[11:9] ^ 3'b100;
                `OP_MOVE_A0, `OP_MOVE_A1, `OP_LONG_IMM: r_field <= instr.move.rsel;
                default: r_field <= r_field;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            short_load    <= 1'b0;
            long_load     <= 1'b0;
            acc_load      <= 1'b0;
            xaau_imm_load <= 1'b0;
            xaau_acc_load <= 1'b0;
            con_check     <= 1'b0;
            goto_ja       <= 1'b0;
            goto_b        <= 1'b0;
            call_ja       <= 1'b0;
            pc_halt       <= 1'b0;
            irq_start     <= 1'b0;
            double        <= 1'b0;
            iret_seen     <= 1'b0;
            do_load       <= 1'b0;
            fault         <= 1'b0;
        end else if (cen) begin
            short_load    <= 1'b0;
            long_load     <= 1'b0;
            acc_load      <= 1'b0;
            xaau_imm_load <= 1'b0;
            xaau_acc_load <= 1'b0;
            con_check     <= 1'b0;
            goto_ja       <= 1'b0;
            goto_b        <= 1'b0;
            call_ja       <= 1'b0;
            pc_halt       <= 1'b0;
            irq_start     <= 1'b0;
            double        <= 1'b0;
            iret_seen     <= 1'b0;
            do_load       <= 1'b0;

            // Second cycle of a two-cycle word ignores rom_dout
            if (!double) begin
                if (irq_take) begin
                    goto_ja   <= 1'b1;      // Jump to the vector
                    irq_start <= 1'b1;
                    pc_halt   <= 1'b1;
                    double    <= 1'b1;
                end else begin
                    casez (instr.branch.op)
                        `OP_GOTO_JA: begin
                            goto_ja <= con_ok;
                            pc_halt <= 1'b1;
                            double  <= 1'b1;
                            if (do_busy) fault <= 1'b1;
                        end
                        `OP_CALL_JA: begin
                            call_ja <= con_ok;
                            pc_halt <= 1'b1;
                            double  <= 1'b1;
                            if (do_busy) fault <= 1'b1;
                        end
                        `OP_GOTO_B: begin
                            goto_b    <= con_ok || is_iret;   // iret ignores CON
                            iret_seen <= is_iret;
                            pc_halt   <= 1'b1;
                            double    <= 1'b1;
                            if (do_busy) fault <= 1'b1;
                        end
                        `OP_SHORT_IMM: short_load <= 1'b1;
                        `OP_LONG_IMM: begin
                            long_load     <= instr.move.dest == {1'b0, `DEST_YAAU};
                            xaau_imm_load <= instr.move.dest == {1'b0, `DEST_XAAU};
                            double        <= 1'b1;    // PC moves on to the data word
                            if (do_busy) fault <= 1'b1;
                        end
                        `OP_MOVE_A0, `OP_MOVE_A1: begin
                            acc_load      <= instr.move.dest[1:0] == `DEST_YAAU;
                            xaau_acc_load <= instr.move.dest[1:0] == `DEST_XAAU;
                            pc_halt       <= 1'b1;
                            double        <= 1'b1;
                        end
                        `OP_IF_CON: begin
                            if (!instr.branch.addr[10]) con_check <= 1'b1;
                        end
                        `OP_DO: begin
                            do_load <= 1'b1;
                            if (instr.do_op.ni == '0) begin   // redo
                                pc_halt <= 1'b1;
                                double  <= 1'b1;
                            end
                        end
                        default: fault <= 1'b1;     // Unknown opcode
                    endcase
                end
            end

            // Loop cache fill and loop exit
            if (do_stretch) begin
                pc_halt <= 1'b1;
                double  <= 1'b1;
            end
        end
    end

endmodule

// ==== hw/ctrl_top.sv ====
`timescale 1ns/1ps

module ctrl_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  ctrl_pkg::dsp_word_t rom_dout,
    input  logic                con_result,
    input  logic                irq,
    output logic                short_load,
    output logic                long_load,
    output logic                acc_load,
    output logic                xaau_imm_load,
    output logic                xaau_acc_load,
    output logic [2:0]          r_field,
    output logic [8:0]          short_imm,
    output ctrl_pkg::dsp_word_t long_imm,
    output logic [11:0]         i_field,
    output ctrl_pkg::t_field_t  t_field,
    output logic                con_check,
    output logic                goto_ja,
    output logic                goto_b,
    output logic                call_ja,
    output logic                pc_halt,
    output logic                irq_start,
    output logic                iack,
    output logic                do_start,
    output logic                do_out,
    output logic                do_short,
    output logic                do_redo,
    output logic                do_save,
    output ctrl_pkg::do_ni_t    do_pc,
    output logic                fault
);
    import ctrl_pkg::*;

    // Decoder to loop and irq units
    logic   double;
    logic   iret_seen;
    logic   do_load;
    do_ni_t do_ni_in;
    do_k_t  do_k_in;
    logic   do_redo_req;

    // Back into the decoder
    logic   irq_take;
    logic   do_busy;
    logic   do_stretch;

    instr_decode instr_decode_inst (.*);

    do_loop_ctrl do_loop_ctrl_inst (.*);

    irq_gate irq_gate_inst (
        .op (rom_dout[15:11]),  // T field
        .*
    );

endmodule

// ==== tests/ctrl_tb.sv ====
`timescale 1ns/1ps
`include "ctrl_defs.svh"

module ctrl_tb;
    import ctrl_pkg::*;

    localparam int N_ROWS = 26;
    localparam int WATCHDOG_CYCLES = N_ROWS * 4 + 200;
    localparam dsp_word_t FILLER = 16'h1000;     // Interruptible short immediate

    // Expected strobe bits in the order of act in check_row
    localparam logic [12:0] XA = 13'h1000;  // xaau_acc_load
    localparam logic [12:0] GJ = 13'h0800;  // goto_ja
    localparam logic [12:0] GB = 13'h0400;  // goto_b
    localparam logic [12:0] CJ = 13'h0200;  // call_ja
    localparam logic [12:0] PH = 13'h0100;  // pc_halt
    localparam logic [12:0] SL = 13'h0080;  // short_load
    localparam logic [12:0] LL = 13'h0040;  // long_load
    localparam logic [12:0] XI = 13'h0020;  // xaau_imm_load
    localparam logic [12:0] AL = 13'h0010;  // acc_load
    localparam logic [12:0] CC = 13'h0008;  // con_check
    localparam logic [12:0] IS = 13'h0004;  // irq_start
    localparam logic [12:0] IA = 13'h0002;  // iack
    localparam logic [12:0] FT = 13'h0001;  // fault

    logic clk, rst, cen, con_result, irq;
    dsp_word_t rom_dout, long_imm;
    logic short_load, long_load, acc_load, xaau_imm_load, xaau_acc_load;
    logic [2:0] r_field;
    logic [8:0] short_imm;
    logic [11:0] i_field;
    t_field_t t_field;
    logic con_check, goto_ja, goto_b, call_ja, pc_halt, irq_start, iack, fault;
    logic do_start, do_out, do_short, do_redo, do_save;
    do_ni_t do_pc;

    dsp_word_t   tbl_word [N_ROWS];
    logic        tbl_irq  [N_ROWS];
    logic        tbl_con  [N_ROWS];
    logic [12:0] tbl_exp  [N_ROWS];
    int          n_rows;
    logic [31:0] rng_state;
    string sig_name [13] = '{"fault", "iack", "irq_start", "con_check", "acc_load",
        "xaau_imm_load", "long_load", "short_load", "pc_halt", "call_ja", "goto_b", "goto_ja",
        "xaau_acc_load"};

    ctrl_top ctrl_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the test did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic draw(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input dsp_word_t exp, input dsp_word_t act);
        if (act !== exp)
            report_failure($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_ni(input string name, input do_ni_t exp, input do_ni_t act);
        if (act !== exp)
            report_failure($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            report_failure($sformatf("** Error %s: expected %b, actual %b", name, exp, act));
    endtask

    task automatic add_row(input dsp_word_t w, input logic i, input logic c, input logic [12:0] e);
        tbl_word[n_rows] = w;
        tbl_irq[n_rows]  = i;
        tbl_con[n_rows]  = c;
        tbl_exp[n_rows]  = e;
        n_rows++;
    endtask

    task automatic build_table;
        logic [31:0] r;
        n_rows = 0;
        add_row(16'h0123, 0, 0, GJ | PH);                        // goto JA
        add_row(FILLER, 0, 0, '0);                               // Second cycle is ignored
        draw(r);
        add_row(FILLER | dsp_word_t'(r[11:0]), 0, 0, SL);        // Random short immediate
        add_row({`OP_LONG_IMM, 11'h000}, 0, 0, LL);              // R=imm to YAAU
        draw(r);
        add_row(r[15:0], 0, 0, '0);                              // Data word
        add_row({`OP_LONG_IMM, 11'h080}, 0, 0, XI);              // R=imm to XAAU
        draw(r);
        add_row(r[31:16], 0, 0, '0);
        add_row({`OP_IF_CON, 11'h000}, 0, 0, CC);
        add_row(16'h8055, 0, 0, PH);                             // call JA with a false condition
        add_row(FILLER, 0, 0, '0);
        add_row({`OP_IF_CON, 11'h000}, 0, 1, CC);
        add_row(16'h8055, 0, 1, CJ | PH);                        // call JA with a true condition
        add_row(FILLER, 0, 0, '0);
        add_row(FILLER, 1, 0, GJ | IS | PH | IA);                // Interrupt taken
        add_row(FILLER, 1, 0, IA);
        draw(r);
        add_row(FILLER | dsp_word_t'(r[11:0]), 1, 0, SL | IA);   // irq ignored while iack
        add_row({`OP_GOTO_B, `IRET_CODE, 8'h00}, 0, 0, GB | PH | IA);
        add_row(FILLER, 0, 0, IA);
        add_row(FILLER, 0, 0, SL);                               // iack clears here
        add_row({`OP_MOVE_A0, 11'h000}, 0, 0, AL | PH);
        add_row(FILLER, 0, 0, '0);
        add_row({`OP_MOVE_A1, 11'h080}, 0, 0, XA | PH);          // R=a1 to XAAU
        add_row(FILLER, 0, 0, '0);
        add_row(16'hF800, 0, 0, FT);                             // Unknown opcode
        add_row(FILLER, 0, 0, SL | FT);
        add_row(FILLER, 1, 0, GJ | IS | PH | IA | FT);           // iack still set at the reset
    endtask

    task automatic check_row(input int i);
        logic [12:0] act;
        dsp_word_t w;
        act = {xaau_acc_load, goto_ja, goto_b, call_ja, pc_halt, short_load, long_load,
               xaau_imm_load, acc_load, con_check, irq_start, iack, fault};
        w = tbl_word[i];
        for (int b = 0; b < 13; b++)
            check_bit($sformatf("row %0d %s", i, sig_name[b]), tbl_exp[i][b], act[b]);
        check_word($sformatf("row %0d t_field", i), dsp_word_t'(w[15:11]),
                   dsp_word_t'(t_field));
        check_word($sformatf("row %0d i_field", i), dsp_word_t'(w[11:0]),
                   dsp_word_t'(i_field));
        if (tbl_exp[i][7]) begin
            check_word($sformatf("row %0d r_field", i), dsp_word_t'({~w[11], w[10:9]}),
                       dsp_word_t'(r_field));
            check_word($sformatf("row %0d short_imm", i), dsp_word_t'(w[8:0]),
                       dsp_word_t'(short_imm));
        end
    endtask

    task automatic run_table;
        for (int i = 0; i <= n_rows; i++) begin
            @(posedge clk);
            rom_dout   <= (i < n_rows) ? tbl_word[i] : FILLER;
            irq        <= (i < n_rows) ? tbl_irq[i] : 1'b0;
            con_result <= (i < n_rows) ? tbl_con[i] : 1'b0;
            @(negedge clk);
            if (i > 0) check_row(i - 1);
            if (i < n_rows) check_word($sformatf("row %0d long_imm", i), tbl_word[i], long_imm);
        end
    endtask

    task automatic apply_reset;
        @(posedge clk);
        rst      <= 1'b1;
        rom_dout <= FILLER;
        irq      <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bit("fault after reset", 1'b0, fault);
        check_bit("iack after reset", 1'b0, iack);
        check_ni("do_pc after reset", '0, do_pc);
    endtask

    task automatic run_do_loop;
        logic [31:0] r;
        do_ni_t ni;
        do_ni_t prev_pc;
        do_k_t k;
        int cycles, limit, saves, starts, outs, wraps, post;
        draw(r);
        ni = do_ni_t'(2 + r % 4);
        draw(r);
        k = do_k_t'(1 + r % 8);
        limit = (int'(ni) + 2) * int'(k) + 20;
        {cycles, saves, starts, outs, wraps, post} = '0;
        prev_pc = do_pc;
        @(posedge clk);
        rom_dout <= {`OP_DO, ni, k};
        while (post < 4) begin
            @(posedge clk);
            rom_dout <= FILLER;
            @(negedge clk);
            cycles++;
            if (cycles > limit) report_failure("The do loop never raised do_out");
            check_bit("do_short with a body of two or more", 1'b0, do_short);
            check_bit("do_redo after a plain do", 1'b0, do_redo);
            if (do_save) saves++;
            if (do_start) starts++;
            if (do_out) outs++;
            if (prev_pc != '0 && do_pc == '0) wraps++;   // End of one pass
            prev_pc = do_pc;
            if (outs != 0) post++;
        end
        check_word("do_save pulses", 16'd1, dsp_word_t'(saves));
        check_word("do_start pulses", 16'd1, dsp_word_t'(starts));
        check_word("do_out pulses", 16'd1, dsp_word_t'(outs));
        check_word("do passes", dsp_word_t'(k), dsp_word_t'(wraps));
        check_ni("do_pc after loop", '0, do_pc);
    endtask

    task automatic busy_goto_fault;
        @(posedge clk);
        rom_dout <= {`OP_DO, 4'd15, 7'd3};   // Long body, still running at the next reset
        @(posedge clk);
        rom_dout <= FILLER;
        @(posedge clk);
        rom_dout <= 16'h0040;      // goto JA reaches the decoder with the loop active
        @(negedge clk);
        check_bit("fault before goto in loop", 1'b0, fault);
        repeat (20) begin
            @(posedge clk);
            rom_dout <= FILLER;
            @(negedge clk);
            check_bit("fault after goto in loop", 1'b1, fault);
        end
    endtask

    initial begin
        rst        = 1'b1;
        cen        = 1'b1;
        rom_dout   = FILLER;
        irq        = 1'b0;
        con_result = 1'b0;
        rng_state  = 32'd2012;
        build_table();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        run_table();
        apply_reset();
        run_do_loop();
        busy_goto_fault();
        apply_reset();
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+hw
hw/ctrl_pkg.sv
hw/irq_gate.sv
hw/do_loop_ctrl.sv
hw/instr_decode.sv
hw/ctrl_top.sv
tests/ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f filelist.f --top-module ctrl_tb -Mdir obj_dir -o ctrl_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/ctrl_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q ">>> FAIL" "$LOG"; then
    echo "Simulation failed"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi
if ! grep -q ">>> PASS" "$LOG"; then
    echo "No pass line found in $LOG"
    exit 1
fi
exit 0
